// File: src.f
hdl/axi_lint_pkg.sv
hdl/lint64_to_32.sv
hdl/axi_write_ctrl.sv
hdl/axi_read_ctrl.sv
hdl/axi64_2_lint32.sv
verif/lint_mem_model.sv
verif/tb_axi64_2_lint32.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_axi64_2_lint32
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: verif/tb_axi64_2_lint32.sv
// Testbench for the AXI64 to LINT32 bridge
// Stimulus table of write and read bursts applied in a loop
// Reference byte memory, compare tasks per result type
// LINT request monitor for write enables and read byte enables
// Two LINT memory models with random grants, random B and R ready, watchdog

`timescale 1ns/1ps

module tb_axi64_2_lint32
   import axi_lint_pkg::*;
();

   localparam int          ID_W            = 7;
   localparam int          N_OPS           = 12;
   localparam int          CYCLES_PER_BEAT = 40;
   localparam logic [31:0] SEED            = 32'h972d_5a1a;

   typedef struct packed {
      logic             is_write;
      logic [ID_W-1:0]  id;
      axi_addr_t        addr;
      axi_len_t         len;
      axi_burst_t       burst;
      logic [31:0]      seed;    // Beat data and strobes, mode in bits 31:30
   } op_t;

   logic clk;
   logic rst_n_i;

   axi_addr_t        AW_ADDR_i, AR_ADDR_i;
   axi_len_t         AW_LEN_i, AR_LEN_i;
   axi_burst_t       AW_BURST_i, AR_BURST_i;
   logic [ID_W-1:0]  AW_ID_i, AR_ID_i, B_ID_o, R_ID_o;
   logic             AW_VALID_i, AW_READY_o, AR_VALID_i, AR_READY_o;
   axi_data_t        W_DATA_i, R_DATA_o;
   axi_strb_t        W_STRB_i;
   logic             W_LAST_i, W_VALID_i, W_READY_o;
   logic             B_VALID_o, B_READY_i;
   logic             R_LAST_o, R_VALID_o, R_READY_i;

   logic [1:0]        w_req, w_wen, w_gnt, w_rvalid;
   axi_addr_t [1:0]   w_add;
   lint_data_t [1:0]  w_wdata, w_rdata;
   lint_be_t [1:0]    w_be;
   logic [1:0]        r_req, r_wen, r_gnt, r_rvalid;
   axi_addr_t [1:0]   r_add;
   lint_data_t [1:0]  r_wdata, r_rdata;
   lint_be_t [1:0]    r_be;

   integer      seed;
   op_t         ops [N_OPS];
   logic [7:0]  ref_mem [axi_addr_t];
   logic        table_ready = 1'b0;

   initial clk = 1'b0;
   always #50 clk = ~clk;

   axi64_2_lint32 #(
      .AXI_ID_WIDTH ( ID_W )
   ) DUT (
      .clk              ( clk        ),
      .rst_n_i          ( rst_n_i    ),
      .AW_ADDR_i        ( AW_ADDR_i  ),
      .AW_LEN_i         ( AW_LEN_i   ),
      .AW_BURST_i       ( AW_BURST_i ),
      .AW_ID_i          ( AW_ID_i    ),
      .AW_VALID_i       ( AW_VALID_i ),
      .AW_READY_o       ( AW_READY_o ),
      .W_DATA_i         ( W_DATA_i   ),
      .W_STRB_i         ( W_STRB_i   ),
      .W_LAST_i         ( W_LAST_i   ),
      .W_VALID_i        ( W_VALID_i  ),
      .W_READY_o        ( W_READY_o  ),
      .B_ID_o           ( B_ID_o     ),
      .B_VALID_o        ( B_VALID_o  ),
      .B_READY_i        ( B_READY_i  ),
      .AR_ADDR_i        ( AR_ADDR_i  ),
      .AR_LEN_i         ( AR_LEN_i   ),
      .AR_BURST_i       ( AR_BURST_i ),
      .AR_ID_i          ( AR_ID_i    ),
      .AR_VALID_i       ( AR_VALID_i ),
      .AR_READY_o       ( AR_READY_o ),
      .R_ID_o           ( R_ID_o     ),
      .R_DATA_o         ( R_DATA_o   ),
      .R_LAST_o         ( R_LAST_o   ),
      .R_VALID_o        ( R_VALID_o  ),
      .R_READY_i        ( R_READY_i  ),
      .data_W_req_o     ( w_req      ),
      .data_W_wen_o     ( w_wen      ),
      .data_W_add_o     ( w_add      ),
      .data_W_wdata_o   ( w_wdata    ),
      .data_W_be_o      ( w_be       ),
      .data_W_gnt_i     ( w_gnt      ),
      .data_W_r_valid_i ( w_rvalid   ),
      .data_W_r_rdata_i ( w_rdata    ),
      .data_R_req_o     ( r_req      ),
      .data_R_wen_o     ( r_wen      ),
      .data_R_add_o     ( r_add      ),
      .data_R_wdata_o   ( r_wdata    ),
      .data_R_be_o      ( r_be       ),
      .data_R_gnt_i     ( r_gnt      ),
      .data_R_r_valid_i ( r_rvalid   ),
      .data_R_r_rdata_i ( r_rdata    )
   );

   lint_mem_model #(
      .SEED ( SEED ^ 32'h0000_0001 )
   ) u_mem_w (
      .clk       ( clk      ),
      .rst_n_i   ( rst_n_i  ),
      .req_i     ( w_req    ),
      .wen_i     ( w_wen    ),
      .add_i     ( w_add    ),
      .wdata_i   ( w_wdata  ),
      .be_i      ( w_be     ),
      .gnt_o     ( w_gnt    ),
      .r_valid_o ( w_rvalid ),
      .r_rdata_o ( w_rdata  )
   );

   lint_mem_model #(
      .SEED ( SEED ^ 32'h0000_0002 )
   ) u_mem_r (
      .clk       ( clk      ),
      .rst_n_i   ( rst_n_i  ),
      .req_i     ( r_req    ),
      .wen_i     ( r_wen    ),
      .add_i     ( r_add    ),
      .wdata_i   ( r_wdata  ),
      .be_i      ( r_be     ),
      .gnt_o     ( r_gnt    ),
      .r_valid_o ( r_rvalid ),
      .r_rdata_o ( r_rdata  )
   );

   //////////////////////////////////////////////////
   // Error handling and compare tasks
   //////////////////////////////////////////////////
   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Testbench failed");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
      if (got !== exp)
         stop_run($sformatf("Mismatch on %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_id(input string name, input logic [ID_W-1:0] got,
                           input logic [ID_W-1:0] exp);
      if (got !== exp)
         stop_run($sformatf("Mismatch on %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         stop_run($sformatf("Mismatch on %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_be(input string name, input lint_be_t got, input lint_be_t exp);
      if (got !== exp)
         stop_run($sformatf("Mismatch on %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   // Every LINT request carries the enables of its direction
   always @(negedge clk) begin
      if (rst_n_i) begin
         for (int k = 0; k < 2; k++) begin
            if (w_req[k])
               check_flag($sformatf("data_W_wen_o[%0d]", k), w_wen[k], 1'b0);
            if (r_req[k]) begin
               check_flag($sformatf("data_R_wen_o[%0d]", k), r_wen[k], 1'b1);
               check_be($sformatf("data_R_be_o[%0d]", k), r_be[k], 4'hF);
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Stimulus table and reference model
   //////////////////////////////////////////////////
   function automatic void load_table();
      ops[0]  = '{1'b1, 7'h11, 32'h0000_1000, 8'd3,  BURST_INCR,  32'h0000_1111};
      ops[1]  = '{1'b0, 7'h22, 32'h0000_1000, 8'd3,  BURST_INCR,  32'h0};
      ops[2]  = '{1'b1, 7'h05, 32'h0000_1008, 8'd1,  BURST_INCR,  32'h4000_2222}; // Lower only
      ops[3]  = '{1'b1, 7'h06, 32'h0000_1018, 8'd0,  BURST_INCR,  32'h8000_3333}; // Upper only
      ops[4]  = '{1'b0, 7'h33, 32'h0000_1000, 8'd3,  BURST_INCR,  32'h0};
      ops[5]  = '{1'b1, 7'h44, 32'h0000_2004, 8'd5,  BURST_FIXED, 32'hc000_4444};
      ops[6]  = '{1'b0, 7'h55, 32'h0000_2000, 8'd0,  BURST_INCR,  32'h0};
      ops[7]  = '{1'b1, 7'h7f, 32'h0000_3000, 8'd7,  BURST_INCR,  32'hc000_5555};
      ops[8]  = '{1'b0, 7'h01, 32'h0000_3000, 8'd7,  BURST_INCR,  32'h0};
      ops[9]  = '{1'b0, 7'h02, 32'h0000_1008, 8'd2,  BURST_FIXED, 32'h0};
      ops[10] = '{1'b1, 7'h60, 32'h0000_1000, 8'd15, BURST_INCR,  32'h0000_6666};
      ops[11] = '{1'b0, 7'h61, 32'h0000_0ff8, 8'd17, BURST_INCR,  32'h0}; // Unwritten edges
   endfunction

   function automatic axi_data_t beat_data(input logic [31:0] s, input int b);
      logic [31:0] x;
      x = s + 32'(b) * 32'h9e37_79b9;
      return {~x, x ^ {x[15:0], x[31:16]}};
   endfunction

   function automatic axi_strb_t beat_strb(input logic [31:0] s, input int b);
      logic [31:0] x;
      x = s + 32'(b) * 32'h9e37_79b9;
      case (s[31:30])
         2'b00:   return 8'hff;
         2'b01:   return 8'h0f;
         2'b10:   return 8'hf0;
         default: return x[19:12];
      endcase
   endfunction

   // Aligned start, step 8 for INCR, fixed for FIXED
   function automatic axi_addr_t beat_addr(input op_t op, input int b);
      axi_addr_t base;
      base = {op.addr[31:3], 3'b000};
      if (op.burst == BURST_INCR)
         return base + 32'(b) * BEAT_BYTES;
      return base;
   endfunction

   task automatic ref_write(input axi_addr_t a, input axi_data_t d, input axi_strb_t s);
      for (int i = 0; i < 8; i++) begin
         if (s[i])
            ref_mem[a + 32'(i)] = d[8*i +: 8];
      end
   endtask

   function automatic axi_data_t ref_read(input axi_addr_t a);
      axi_data_t   d;
      axi_addr_t   ba;
      lint_data_t  w;
      for (int i = 0; i < 8; i++) begin
         ba = a + 32'(i);
         if (ref_mem.exists(ba)) begin
            d[8*i +: 8] = ref_mem[ba];
         end else begin
            w = u_mem_w.fill_word({ba[31:2], 2'b00});
            d[8*i +: 8] = w[8*int'(ba[1:0]) +: 8];
         end
      end
      return d;
   endfunction

   function automatic logic rand_bit();
      logic [31:0] r;
      r = $random(seed);
      return r[0];
   endfunction

   //////////////////////////////////////////////////
   // Bus tasks, entered 1 ns after a rising edge
   //////////////////////////////////////////////////
   task automatic take_b(input logic [ID_W-1:0] id);
      logic done;
      done = 1'b0;
      while (!done) begin
         B_READY_i = rand_bit();
         @(negedge clk);
         if (B_VALID_o && B_READY_i) begin
            check_id("B_ID_o", B_ID_o, id);
            done = 1'b1;
         end
         @(posedge clk);
         #1;
      end
      B_READY_i = 1'b0;
      @(negedge clk);
      check_flag("B_VALID_o", B_VALID_o, 1'b0);   // One response per burst
      check_flag("AW_READY_o", AW_READY_o, 1'b1);
      @(posedge clk);
      #1;
   endtask

   task automatic do_write(input op_t op);
      axi_data_t  data;
      axi_strb_t  strb;
      int         nbeats;
      nbeats = int'(op.len) + 1;
      AW_ADDR_i  = op.addr;
      AW_LEN_i   = op.len;
      AW_BURST_i = op.burst;
      AW_ID_i    = op.id;
      AW_VALID_i = 1'b1;
      do @(negedge clk); while (!AW_READY_o);
      @(posedge clk);
      #1;
      AW_VALID_i = 1'b0;
      for (int b = 0; b < nbeats; b++) begin
         data = beat_data(op.seed, b);
         strb = beat_strb(op.seed, b);
         W_DATA_i  = data;
         W_STRB_i  = strb;
         W_LAST_i  = (b == nbeats - 1);
         W_VALID_i = 1'b1;
         do @(negedge clk); while (!W_READY_o);
         ref_write(beat_addr(op, b), data, strb);
         @(posedge clk);
         #1;
      end
      W_VALID_i = 1'b0;
      W_LAST_i  = 1'b0;
      take_b(op.id);
   endtask

   task automatic do_read(input op_t op);
      axi_data_t  exp;
      int         nbeats;
      int         b;
      nbeats = int'(op.len) + 1;
      AR_ADDR_i  = op.addr;
      AR_LEN_i   = op.len;
      AR_BURST_i = op.burst;
      AR_ID_i    = op.id;
      AR_VALID_i = 1'b1;
      do @(negedge clk); while (!AR_READY_o);
      @(posedge clk);
      #1;
      AR_VALID_i = 1'b0;
      b = 0;
      while (b < nbeats) begin
         R_READY_i = rand_bit();
         @(negedge clk);
         if (R_VALID_o && R_READY_i) begin
            exp = ref_read(beat_addr(op, b));
            check_data("R_DATA_o", R_DATA_o, exp);
            check_id("R_ID_o", R_ID_o, op.id);
            check_flag("R_LAST_o", R_LAST_o, b == nbeats - 1);
            b++;
         end
         @(posedge clk);
         #1;
      end
      R_READY_i = 1'b0;
      @(negedge clk);
      check_flag("R_VALID_o", R_VALID_o, 1'b0);   // No extra beat
      check_flag("AR_READY_o", AR_READY_o, 1'b1);
      @(posedge clk);
      #1;
   endtask

   //////////////////////////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////////////////////////
   initial begin
      seed = SEED;
      load_table();
      table_ready = 1'b1;
      rst_n_i    = 1'b0;
      AW_ADDR_i  = '0;
      AW_LEN_i   = '0;
      AW_BURST_i = '0;
      AW_ID_i    = '0;
      AW_VALID_i = 1'b0;
      W_DATA_i   = '0;
      W_STRB_i   = '0;
      W_LAST_i   = 1'b0;
      W_VALID_i  = 1'b0;
      B_READY_i  = 1'b0;
      AR_ADDR_i  = '0;
      AR_LEN_i   = '0;
      AR_BURST_i = '0;
      AR_ID_i    = '0;
      AR_VALID_i = 1'b0;
      R_READY_i  = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      rst_n_i = 1'b1;
      @(negedge clk);
      check_flag("B_VALID_o", B_VALID_o, 1'b0);
      check_flag("R_VALID_o", R_VALID_o, 1'b0);
      check_flag("data_W_req_o", |w_req, 1'b0);
      check_flag("data_R_req_o", |r_req, 1'b0);
      check_flag("AW_READY_o", AW_READY_o, 1'b1);
      check_flag("AR_READY_o", AR_READY_o, 1'b1);
      @(posedge clk);
      #1;
      for (int i = 0; i < N_OPS; i++) begin
         if (ops[i].is_write)
            do_write(ops[i]);
         else
            do_read(ops[i]);
      end
      $display("Testbench passed");
      $finish;
   end

   initial begin : watchdog
      int beats;
      wait (table_ready);
      beats = 0;
      for (int i = 0; i < N_OPS; i++)
         beats += int'(ops[i].len) + 1;
      repeat (beats * CYCLES_PER_BEAT) @(posedge clk);
      stop_run($sformatf("Timeout: test not finished after %0d cycles",
                         beats * CYCLES_PER_BEAT));
   end

endmodule

// File: verif/lint_mem_model.sv
// LINT slave model for one pair of 32-bit ports
// Random grant per port, response one cycle after the grant
// Word memory shared through the write pair's instance

`timescale 1ns/1ps

module lint_mem_model
   import axi_lint_pkg::*;
#(
   parameter logic [31:0] SEED = 32'h972d_5a1a
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic [1:0]        req_i,
   input  logic [1:0]        wen_i,      // Active low write
   input  axi_addr_t [1:0]   add_i,
   input  lint_data_t [1:0]  wdata_i,
   input  lint_be_t [1:0]    be_i,
   output logic [1:0]        gnt_o,
   output logic [1:0]        r_valid_o,
   output lint_data_t [1:0]  r_rdata_o
);

   lint_data_t   mem [axi_addr_t];   // Only the write pair's copy is used
   integer       seed;
   logic [31:0]  draw;

   initial seed = SEED;

   // Content of a word that was never written
   function automatic lint_data_t fill_word(input axi_addr_t a);
      return (a * 32'h9e37_79b1) ^ 32'h5ca1_ab1e;
   endfunction

   function automatic lint_data_t load_word(input axi_addr_t a);
      if (tb_axi64_2_lint32.u_mem_w.mem.exists(a))
         return tb_axi64_2_lint32.u_mem_w.mem[a];
      return fill_word(a);
   endfunction

   task automatic store_word(input axi_addr_t a, input lint_data_t d, input lint_be_t be);
      lint_data_t w;
      w = mem.exists(a) ? mem[a] : fill_word(a);
      for (int i = 0; i < 4; i++) begin
         if (be[i])
            w[8*i +: 8] = d[8*i +: 8];
      end
      mem[a] = w;
   endtask

   always @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gnt_o     <= '0;
         r_valid_o <= '0;
         r_rdata_o <= '0;
      end else begin
         draw = $random(seed);
         gnt_o <= draw[1:0];  // Grant stalls per port
         for (int k = 0; k < 2; k++) begin
            r_valid_o[k] <= req_i[k] & gnt_o[k];
            if (req_i[k] && gnt_o[k]) begin
               if (!wen_i[k])
                  store_word(add_i[k], wdata_i[k], be_i[k]);
               r_rdata_o[k] <= load_word(add_i[k]);
            end
         end
      end
   end

endmodule

// File: hdl/axi64_2_lint32.sv
// Bridge from a 64-bit AXI slave to two 32-bit LINT master pairs
// Write path goes through the write controller and a write splitter
// Read path goes through the read controller and a read splitter

`timescale 1ns/1ps

module axi64_2_lint32
   import axi_lint_pkg::*;
#(
   parameter int AXI_ID_WIDTH = 7
) (
   input  logic                     clk,
   input  logic                     rst_n_i,

   // Write address channel
   input  axi_addr_t                AW_ADDR_i,
   input  axi_len_t                 AW_LEN_i,
   input  axi_burst_t               AW_BURST_i,
   input  logic [AXI_ID_WIDTH-1:0]  AW_ID_i,
   input  logic                     AW_VALID_i,
   output logic                     AW_READY_o,
   // Write data channel
   input  axi_data_t                W_DATA_i,
   input  axi_strb_t                W_STRB_i,
   input  logic                     W_LAST_i,
   input  logic                     W_VALID_i,
   output logic                     W_READY_o,
   // Write response channel
   output logic [AXI_ID_WIDTH-1:0]  B_ID_o,
   output logic                     B_VALID_o,
   input  logic                     B_READY_i,
   // Read address channel
   input  axi_addr_t                AR_ADDR_i,
   input  axi_len_t                 AR_LEN_i,
   input  axi_burst_t               AR_BURST_i,
   input  logic [AXI_ID_WIDTH-1:0]  AR_ID_i,
   input  logic                     AR_VALID_i,
   output logic                     AR_READY_o,
   // Read data channel
   output logic [AXI_ID_WIDTH-1:0]  R_ID_o,
   output axi_data_t                R_DATA_o,
   output logic                     R_LAST_o,
   output logic                     R_VALID_o,
   input  logic                     R_READY_i,

   // LINT write pair
   output logic [1:0]               data_W_req_o,
   output logic [1:0]               data_W_wen_o,
   output axi_addr_t [1:0]          data_W_add_o,
   output lint_data_t [1:0]         data_W_wdata_o,
   output lint_be_t [1:0]           data_W_be_o,
   input  logic [1:0]               data_W_gnt_i,
   input  logic [1:0]               data_W_r_valid_i,
   input  lint_data_t [1:0]         data_W_r_rdata_i,

   // LINT read pair
   output logic [1:0]               data_R_req_o,
   output logic [1:0]               data_R_wen_o,
   output axi_addr_t [1:0]          data_R_add_o,
   output lint_data_t [1:0]         data_R_wdata_o,
   output lint_be_t [1:0]           data_R_be_o,
   input  logic [1:0]               data_R_gnt_i,
   input  logic [1:0]               data_R_r_valid_i,
   input  lint_data_t [1:0]         data_R_r_rdata_i
);

   // 64-bit request between controllers and splitters
   logic       wr_req;
   axi_addr_t  wr_add;
   axi_data_t  wr_wdata;
   axi_strb_t  wr_be;
   logic       wr_gnt;

   logic       rd_req;
   axi_addr_t  rd_add;
   logic       rd_gnt;
   logic       rd_r_valid;
   axi_data_t  rd_r_rdata;

   //////////////////////////////////////////////////
   // Write path
   //////////////////////////////////////////////////
   axi_write_ctrl #(
      .AXI_ID_WIDTH ( AXI_ID_WIDTH )
   ) i_axi_write_ctrl (
      .clk         ( clk        ),
      .rst_n_i     ( rst_n_i    ),
      .AW_ADDR_i   ( AW_ADDR_i  ),
      .AW_LEN_i    ( AW_LEN_i   ),
      .AW_BURST_i  ( AW_BURST_i ),
      .AW_ID_i     ( AW_ID_i    ),
      .AW_VALID_i  ( AW_VALID_i ),
      .AW_READY_o  ( AW_READY_o ),
      .W_DATA_i    ( W_DATA_i   ),
      .W_STRB_i    ( W_STRB_i   ),
      .W_LAST_i    ( W_LAST_i   ),
      .W_VALID_i   ( W_VALID_i  ),
      .W_READY_o   ( W_READY_o  ),
      .B_ID_o      ( B_ID_o     ),
      .B_VALID_o   ( B_VALID_o  ),
      .B_READY_i   ( B_READY_i  ),
      .mem_req_o   ( wr_req     ),
      .mem_add_o   ( wr_add     ),
      .mem_wdata_o ( wr_wdata   ),
      .mem_be_o    ( wr_be      ),
      .mem_gnt_i   ( wr_gnt     )
   );

   lint64_to_32 #(
      .IS_WRITE ( 1'b1 )
   ) parallel_lint_write (
      .clk            ( clk              ),
      .rst_n_i        ( rst_n_i          ),
      .req_i          ( wr_req           ),
      .add_i          ( wr_add           ),
      .wdata_i        ( wr_wdata         ),
      .be_i           ( wr_be            ),
      .gnt_o          ( wr_gnt           ),
      .r_valid_o      (                  ),  // Write acks not needed
      .r_rdata_o      (                  ),
      .data_req_o     ( data_W_req_o     ),
      .data_add_o     ( data_W_add_o     ),
      .data_wdata_o   ( data_W_wdata_o   ),
      .data_be_o      ( data_W_be_o      ),
      .data_wen_o     ( data_W_wen_o     ),
      .data_gnt_i     ( data_W_gnt_i     ),
      .data_r_valid_i ( data_W_r_valid_i ),
      .data_r_rdata_i ( data_W_r_rdata_i )
   );

   //////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////
   axi_read_ctrl #(
      .AXI_ID_WIDTH ( AXI_ID_WIDTH )
   ) i_axi_read_ctrl (
      .clk           ( clk        ),
      .rst_n_i       ( rst_n_i    ),
      .AR_ADDR_i     ( AR_ADDR_i  ),
      .AR_LEN_i      ( AR_LEN_i   ),
      .AR_BURST_i    ( AR_BURST_i ),
      .AR_ID_i       ( AR_ID_i    ),
      .AR_VALID_i    ( AR_VALID_i ),
      .AR_READY_o    ( AR_READY_o ),
      .R_ID_o        ( R_ID_o     ),
      .R_DATA_o      ( R_DATA_o   ),
      .R_LAST_o      ( R_LAST_o   ),
      .R_VALID_o     ( R_VALID_o  ),
      .R_READY_i     ( R_READY_i  ),
      .mem_req_o     ( rd_req     ),
      .mem_add_o     ( rd_add     ),
      .mem_gnt_i     ( rd_gnt     ),
      .mem_r_valid_i ( rd_r_valid ),
      .mem_r_rdata_i ( rd_r_rdata )
   );

   lint64_to_32 #(
      .IS_WRITE ( 1'b0 )
   ) parallel_lint_read (
      .clk            ( clk              ),
      .rst_n_i        ( rst_n_i          ),
      .req_i          ( rd_req           ),
      .add_i          ( rd_add           ),
      .wdata_i        ( '0               ),
      .be_i           ( '1               ),  // Reads fetch both words
      .gnt_o          ( rd_gnt           ),
      .r_valid_o      ( rd_r_valid       ),
      .r_rdata_o      ( rd_r_rdata       ),
      .data_req_o     ( data_R_req_o     ),
      .data_add_o     ( data_R_add_o     ),
      .data_wdata_o   ( data_R_wdata_o   ),
      .data_be_o      ( data_R_be_o      ),
      .data_wen_o     ( data_R_wen_o     ),
      .data_gnt_i     ( data_R_gnt_i     ),
      .data_r_valid_i ( data_R_r_valid_i ),
      .data_r_rdata_i ( data_R_r_rdata_i )
   );

endmodule

// File: hdl/axi_read_ctrl.sv
// AXI read controller
// Takes one AR burst and fetches one 64-bit word per beat
// Presents each word on R and flags the last beat

`timescale 1ns/1ps

module axi_read_ctrl
   import axi_lint_pkg::*;
#(
   parameter int AXI_ID_WIDTH = 7
) (
   input  logic                     clk,
   input  logic                     rst_n_i,

   input  axi_addr_t                AR_ADDR_i,
   input  axi_len_t                 AR_LEN_i,
   input  axi_burst_t               AR_BURST_i,
   input  logic [AXI_ID_WIDTH-1:0]  AR_ID_i,
   input  logic                     AR_VALID_i,
   output logic                     AR_READY_o,

   output logic [AXI_ID_WIDTH-1:0]  R_ID_o,
   output axi_data_t                R_DATA_o,
   output logic                     R_LAST_o,
   output logic                     R_VALID_o,
   input  logic                     R_READY_i,

   output logic                     mem_req_o,
   output axi_addr_t                mem_add_o,
   input  logic                     mem_gnt_i,
   input  logic                     mem_r_valid_i,
   input  axi_data_t                mem_r_rdata_i
);

   rd_state_e                 state_q, state_d;
   axi_len_t                  cnt_q;
   axi_len_t                  len_q;
   axi_burst_t                burst_q;
   axi_addr_t                 addr_q;
   logic [AXI_ID_WIDTH-1:0]   id_q;
   axi_data_t                 rdata_q;
   logic                      ar_take;
   logic                      beat_done;
   logic                      last_beat;

   assign AR_READY_o = (state_q == RD_IDLE);
   assign ar_take    = AR_VALID_i & AR_READY_o;

   assign mem_req_o = (state_q == RD_REQ);
   assign mem_add_o = addr_q;

   assign last_beat = (cnt_q == len_q);
   assign R_VALID_o = (state_q == RD_DATA);
   assign R_LAST_o  = R_VALID_o & last_beat;
   assign R_ID_o    = id_q;
   assign R_DATA_o  = rdata_q;
   assign beat_done = R_VALID_o & R_READY_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         RD_IDLE: if (ar_take) state_d = RD_REQ;
         RD_REQ:  if (mem_gnt_i) state_d = RD_WAIT;
         RD_WAIT: if (mem_r_valid_i) state_d = RD_DATA;
         RD_DATA: begin
            if (beat_done)
               state_d = last_beat ? RD_IDLE : RD_REQ;
         end
         default: state_d = RD_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= RD_IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         if (ar_take)
            cnt_q <= '0;
         else if (beat_done)
            cnt_q <= cnt_q + 8'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (ar_take) begin
         id_q    <= AR_ID_i;
         len_q   <= AR_LEN_i;
         burst_q <= AR_BURST_i;
         addr_q  <= {AR_ADDR_i[31:3], 3'b000};
      end else if (beat_done && burst_q != BURST_FIXED) begin
         addr_q <= addr_q + BEAT_BYTES;  // Next INCR beat
      end
      if (state_q == RD_WAIT && mem_r_valid_i)
         rdata_q <= mem_r_rdata_i;  // Held while R is stalled
   end

endmodule

// File: hdl/axi_write_ctrl.sv
// AXI write controller
// Takes one AW burst, streams its W beats as 64-bit requests
// Returns a single B response per burst

`timescale 1ns/1ps

module axi_write_ctrl
   import axi_lint_pkg::*;
#(
   parameter int AXI_ID_WIDTH = 7
) (
   input  logic                     clk,
   input  logic                     rst_n_i,

   input  axi_addr_t                AW_ADDR_i,
   input  axi_len_t                 AW_LEN_i,
   input  axi_burst_t               AW_BURST_i,
   input  logic [AXI_ID_WIDTH-1:0]  AW_ID_i,
   input  logic                     AW_VALID_i,
   output logic                     AW_READY_o,

   input  axi_data_t                W_DATA_i,
   input  axi_strb_t                W_STRB_i,
   input  logic                     W_LAST_i,   // Burst end comes from the beat count
   input  logic                     W_VALID_i,
   output logic                     W_READY_o,

   output logic [AXI_ID_WIDTH-1:0]  B_ID_o,
   output logic                     B_VALID_o,
   input  logic                     B_READY_i,

   output logic                     mem_req_o,
   output axi_addr_t                mem_add_o,
   output axi_data_t                mem_wdata_o,
   output axi_strb_t                mem_be_o,
   input  logic                     mem_gnt_i
);

   wr_state_e                 state_q, state_d;
   axi_len_t                  cnt_q;
   axi_len_t                  len_q;
   axi_burst_t                burst_q;
   axi_addr_t                 addr_q;
   logic [AXI_ID_WIDTH-1:0]   id_q;
   logic                      aw_take;
   logic                      beat_done;
   logic                      last_beat;

   assign AW_READY_o = (state_q == WR_IDLE);
   assign aw_take    = AW_VALID_i & AW_READY_o;

   // Beat goes out straight from the W channel
   assign mem_req_o   = (state_q == WR_DATA) & W_VALID_i;
   assign mem_add_o   = addr_q;
   assign mem_wdata_o = W_DATA_i;
   assign mem_be_o    = W_STRB_i;

   assign W_READY_o = (state_q == WR_DATA) & mem_gnt_i;  // Consumed on grant
   assign beat_done = W_VALID_i & W_READY_o;
   assign last_beat = (cnt_q == len_q);

   assign B_VALID_o = (state_q == WR_RESP);
   assign B_ID_o    = id_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         WR_IDLE: if (aw_take) state_d = WR_DATA;
         WR_DATA: if (beat_done && last_beat) state_d = WR_RESP;
         WR_RESP: if (B_READY_i) state_d = WR_IDLE;
         default: state_d = WR_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= WR_IDLE;
         cnt_q   <= '0;
      end else begin
         state_q <= state_d;
         if (aw_take)
            cnt_q <= '0;
         else if (beat_done)
            cnt_q <= cnt_q + 8'd1;
      end
   end

   // Burst fields, held for the whole burst
   always_ff @(posedge clk) begin
      if (aw_take) begin
         id_q    <= AW_ID_i;
         len_q   <= AW_LEN_i;
         burst_q <= AW_BURST_i;
         addr_q  <= {AW_ADDR_i[31:3], 3'b000};  // 64-bit aligned
      end else if (beat_done && burst_q != BURST_FIXED) begin
         addr_q <= addr_q + BEAT_BYTES;
      end
   end

endmodule

// File: hdl/lint64_to_32.sv
// Splitter from one 64-bit LINT request to two 32-bit LINT ports
// Lower word on port 0, upper word on port 1 at address plus 4
// Tracks grants and responses per half and joins the read data

`timescale 1ns/1ps

module lint64_to_32
   import axi_lint_pkg::*;
#(
   parameter bit IS_WRITE = 1'b1
) (
   input  logic              clk,
   input  logic              rst_n_i,

   input  logic              req_i,
   input  axi_addr_t         add_i,
   input  axi_data_t         wdata_i,
   input  axi_strb_t         be_i,
   output logic              gnt_o,
   output logic              r_valid_o,
   output axi_data_t         r_rdata_o,

   output logic [1:0]        data_req_o,
   output axi_addr_t [1:0]   data_add_o,
   output lint_data_t [1:0]  data_wdata_o,
   output lint_be_t [1:0]    data_be_o,
   output logic [1:0]        data_wen_o,
   input  logic [1:0]        data_gnt_i,
   input  logic [1:0]        data_r_valid_i,
   input  lint_data_t [1:0]  data_r_rdata_i
);

   logic [1:0]        en;          // Half carries a request
   logic [1:0]        take_now;
   logic [1:0]        skip_now;
   logic [1:0]        ret_now;
   logic [1:0]        taken_q;
   logic [1:0]        ret_q;
   logic              gnt_done_q;  // Beat granted, responses pending
   lint_data_t [1:0]  rdata_q;

   always_comb begin
      for (int k = 0; k < 2; k++) begin
         en[k]           = IS_WRITE ? (|be_i[4*k +: 4]) : 1'b1;
         data_be_o[k]    = IS_WRITE ? be_i[4*k +: 4] : 4'hF;
         data_wdata_o[k] = wdata_i[32*k +: 32];
         data_req_o[k]   = req_i & ~gnt_done_q & en[k] & ~taken_q[k];
      end
   end

   assign data_add_o[0] = add_i;
   assign data_add_o[1] = add_i + WORD_BYTES;
   assign data_wen_o    = {2{~IS_WRITE}};  // Active low write

   // Disabled halves count as taken and returned at once
   assign take_now  = data_req_o & data_gnt_i;
   assign gnt_o     = req_i & ~gnt_done_q & (&(taken_q | take_now | ~en));
   assign skip_now  = {2{gnt_o}} & ~en;
   assign ret_now   = ret_q | data_r_valid_i | skip_now;
   assign r_valid_o = (gnt_done_q | gnt_o) & (&ret_now);

   // Late word bypasses, early word comes from its register
   assign r_rdata_o[31:0]  = data_r_valid_i[0] ? data_r_rdata_i[0] : rdata_q[0];
   assign r_rdata_o[63:32] = data_r_valid_i[1] ? data_r_rdata_i[1] : rdata_q[1];

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         taken_q    <= '0;
         ret_q      <= '0;
         gnt_done_q <= 1'b0;
      end else if (r_valid_o) begin
         taken_q    <= '0;  // Ready for the next beat
         ret_q      <= '0;
         gnt_done_q <= 1'b0;
      end else begin
         taken_q <= taken_q | take_now;
         ret_q   <= ret_now;
         if (gnt_o)
            gnt_done_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      for (int k = 0; k < 2; k++) begin
         if (data_r_valid_i[k])
            rdata_q[k] <= data_r_rdata_i[k];
      end
   end

endmodule

// File: hdl/axi_lint_pkg.sv
// Shared definitions for the AXI64 to LINT32 bridge
// Bus width types for AXI and LINT
// Burst codes and address steps
// FSM state encodings of the write and read controllers

package axi_lint_pkg;

   typedef logic [31:0] axi_addr_t;   // Byte address, AXI and LINT
   typedef logic [63:0] axi_data_t;   // One AXI beat
   typedef logic [7:0]  axi_strb_t;
   typedef logic [7:0]  axi_len_t;    // Beats minus one
   typedef logic [1:0]  axi_burst_t;

   typedef logic [31:0] lint_data_t;
   typedef logic [3:0]  lint_be_t;

   localparam axi_burst_t BURST_FIXED = 2'd0;
   localparam axi_burst_t BURST_INCR  = 2'd1;

   localparam axi_addr_t BEAT_BYTES = 32'd8;  // INCR step
   localparam axi_addr_t WORD_BYTES = 32'd4;  // Upper word offset

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_DATA,
      WR_RESP
   } wr_state_e;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_REQ,
      RD_WAIT,
      RD_DATA
   } rd_state_e;

endpackage
